// File: l2_cache.f
verilog/l2_cache_pkg.sv
verilog/l2_array_if.sv
verilog/l2_sp_ram.sv
verilog/l2_plru_tree.sv
verilog/l2_tag_data_array.sv
verilog/l2_ctrl.sv
verilog/l2_cache_top.sv
sim/l2_mem_model.sv
sim/l2_cache_assert.sv
sim/tb_l2_cache.sv

// File: sim/l2_cache_assert.sv
`timescale 1ns/1ps
/*
 * Handshake assertions for the L2 cache top level
 */
module l2_cache_assert (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic                           req_valid_i,
  input logic                           req_ready_o,
  input logic                           req_we_i,
  input logic [l2_cache_pkg::ADDR_W-1:0] req_addr_i,
  input l2_cache_pkg::blk_t             req_data_i,
  input logic [l2_cache_pkg::ID_W-1:0]   req_id_i,
  input logic                           rsp_valid_o,
  input logic                           rsp_ready_i,
  input l2_cache_pkg::blk_t             rsp_data_o,
  input logic [l2_cache_pkg::ID_W-1:0]   rsp_id_o,
  input logic                           mem_req_valid_o,
  input logic                           mem_req_ready_i,
  input logic                           mem_req_we_o,
  input logic [l2_cache_pkg::ADDR_W-1:0] mem_req_addr_o,
  input l2_cache_pkg::blk_t             mem_req_data_o,
  input logic                           mem_rsp_valid_i
);

  int unsigned fail_cnt;
  logic        mem_pend_q;

  initial fail_cnt = 0;

  // Set by a transferred memory request, cleared by its response pulse
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mem_pend_q <= 1'b0;
    end else if (mem_req_valid_o && mem_req_ready_i) begin
      mem_pend_q <= 1'b1;
    end else if (mem_rsp_valid_i) begin
      mem_pend_q <= 1'b0;
    end
  end

  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && !req_ready_o |=> req_valid_i &&
      $stable({req_we_i, req_addr_i, req_data_i, req_id_i}))
    else begin
      $error("Request dropped or changed while waiting for ready");
      fail_cnt++;
    end

  rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable({rsp_data_o, rsp_id_o}))
    else begin
      $error("Response dropped or changed while waiting for ready");
      fail_cnt++;
    end

  mem_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o &&
      $stable({mem_req_we_o, mem_req_addr_o, mem_req_data_o}))
    else begin
      $error("Memory request dropped or changed while waiting for ready");
      fail_cnt++;
    end

  mem_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_pend_q |-> !mem_req_valid_o)
    else begin
      $error("Second memory request issued before the pending response");
      fail_cnt++;
    end

endmodule

bind l2_cache_top l2_cache_assert u_assert (.*);

// File: sim/l2_mem_model.sv
`timescale 1ns/1ps
/*
 * Memory responder for the L2 cache testbench
 * Pattern data on reads, random latency of 1 to 8 cycles, log of written lines
 */
module l2_mem_model (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               mem_req_valid_i,
  output logic               mem_req_ready_o,
  input  logic               mem_req_we_i,
  input  logic [31:0]        mem_req_addr_i,
  input  l2_cache_pkg::blk_t mem_req_data_i,
  output logic               mem_rsp_valid_o,
  output l2_cache_pkg::blk_t mem_rsp_data_o
);

  localparam logic [31:0] SEED = 32'hab95_96c6;

  logic [31:0]        rand_state;
  logic               busy;
  int unsigned        wait_cnt;
  logic [31:0]        addr_q;
  int unsigned        rd_count;
  int unsigned        wr_count;
  logic [31:0]        wr_addr_log [64];
  l2_cache_pkg::blk_t wr_data_log [64];

  function automatic int unsigned next_latency();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return (rand_state >> 16) % 8 + 1;
  endfunction

  initial begin
    rand_state      = SEED;
    busy            = 1'b0;
    wait_cnt        = 0;
    rd_count        = 0;
    wr_count        = 0;
    mem_req_ready_o = 1'b0;
    mem_rsp_valid_o = 1'b0;
    mem_rsp_data_o  = '0;
  end

  // Ready drops while a request is pending, so only one is ever outstanding
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      busy = 1'b0;
      mem_req_ready_o <= #1 1'b1;
      mem_rsp_valid_o <= #1 1'b0;
    end else if (busy) begin
      wait_cnt = wait_cnt - 1;
      if (wait_cnt == 0) begin
        busy = 1'b0;
        mem_rsp_valid_o <= #1 1'b1;
        mem_rsp_data_o  <= #1 {4{addr_q}};
        mem_req_ready_o <= #1 1'b1;
      end
    end else begin
      mem_rsp_valid_o <= #1 1'b0;
      if (mem_req_valid_i && mem_req_ready_o) begin
        busy     = 1'b1;
        wait_cnt = next_latency();
        addr_q   = {mem_req_addr_i[31:4], 4'h0};
        if (mem_req_we_i) begin
          if (wr_count < 64) begin
            wr_addr_log[wr_count] = mem_req_addr_i;
            wr_data_log[wr_count] = mem_req_data_i;
          end
          wr_count = wr_count + 1;
        end else begin
          rd_count = rd_count + 1;
        end
        mem_req_ready_o <= #1 1'b0;
      end else begin
        // Idle request channel stalls now and then
        mem_req_ready_o <= #1 (next_latency() > 2);
      end
    end
  end

endmodule

// File: sim/tb_l2_cache.sv
`timescale 1ns/1ps
/*
 * Testbench of the L2 cache
 * Directed tests for miss, hit, write, eviction, back-pressure and flush
 */
module tb_l2_cache;

  localparam int unsigned TIMEOUT = 2000;
  localparam logic [31:0] SEED    = 32'hab95_96c6;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          flush_i;
  logic                          req_valid_i;
  logic                          req_ready_o;
  logic                          req_we_i;
  logic [31:0]                   req_addr_i;
  l2_cache_pkg::blk_t            req_data_i;
  logic [3:0]                    req_id_i;
  logic                          rsp_valid_o;
  logic                          rsp_ready_i;
  l2_cache_pkg::blk_t            rsp_data_o;
  logic [3:0]                    rsp_id_o;
  logic                          mem_req_valid_o;
  logic                          mem_req_ready_i;
  logic                          mem_req_we_o;
  logic [31:0]                   mem_req_addr_o;
  l2_cache_pkg::blk_t            mem_req_data_o;
  logic                          mem_rsp_valid_i;
  l2_cache_pkg::blk_t            mem_rsp_data_i;

  logic [31:0] rand_state = SEED;
  int unsigned value_errs = 0;
  int unsigned other_errs = 0;

  l2_cache_top DUT (.*);

  l2_mem_model u_mem (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_ready_o (mem_req_ready_i),
    .mem_req_we_i    (mem_req_we_o),
    .mem_req_addr_i  (mem_req_addr_o),
    .mem_req_data_i  (mem_req_data_o),
    .mem_rsp_valid_o (mem_rsp_valid_i),
    .mem_rsp_data_o  (mem_rsp_data_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ============================================================
  // Helpers
  // ============================================================
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // Memory fills every word with the line address
  function automatic l2_cache_pkg::blk_t pattern_line(input logic [31:0] addr);
    return {4{addr[31:4], 4'h0}};
  endfunction

  task automatic note_mismatch(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
    $display("ERR %s: expected %0h, actual %0h", name, exp, act);
    value_errs++;
  endtask

  task automatic note_failure(input string what);
    $display("Failure at %0t ns: %s", $time, what);
    other_errs++;
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic send_request(input logic we, input logic [31:0] addr,
                              input l2_cache_pkg::blk_t data, input logic [3:0] id);
    int unsigned n;
    req_valid_i = 1'b1;
    req_we_i    = we;
    req_addr_i  = addr;
    req_data_i  = data;
    req_id_i    = id;
    n = 0;
    @(negedge clk_i);
    while (!req_ready_o && n < TIMEOUT) begin
      n++;
      @(negedge clk_i);
    end
    if (!req_ready_o) begin
      note_failure("request was never accepted");
    end
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic take_response(input string name, input logic [3:0] exp_id,
                               input l2_cache_pkg::blk_t exp_data, input logic stall);
    int unsigned n;
    logic        done;
    logic [31:0] r;
    n    = 0;
    done = 1'b0;
    while (!done && n < TIMEOUT) begin
      r = next_rand();
      rsp_ready_i = stall ? (r[17:16] == 2'b00) : 1'b1;
      @(negedge clk_i);
      if (rsp_valid_o && rsp_ready_i) begin
        done = 1'b1;
        if (rsp_id_o !== exp_id) begin
          note_mismatch({name, " id"}, exp_id, rsp_id_o);
        end
        if (rsp_data_o !== exp_data) begin
          note_mismatch({name, " data"}, exp_data, rsp_data_o);
        end
      end
      n++;
      @(posedge clk_i);
      #1;
    end
    rsp_ready_i = 1'b1;
    if (!done) begin
      note_failure({name, ": no response arrived"});
    end
    @(negedge clk_i);
    if (rsp_valid_o) begin
      note_failure({name, ": response valid stayed high after its transfer"});
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic transact(input string name, input logic we, input logic [31:0] addr,
                          input l2_cache_pkg::blk_t data, input logic [3:0] id,
                          input l2_cache_pkg::blk_t exp_data, input logic stall);
    send_request(we, addr, data, id);
    take_response(name, id, exp_data, stall);
  endtask

  // ============================================================
  // Tests
  // ============================================================
  task automatic read_miss_then_hit();
    logic [31:0] addr;
    int unsigned rd0;
    int unsigned wr0;
    addr = 32'h0000_1048;
    rd0  = u_mem.rd_count;
    wr0  = u_mem.wr_count;
    transact("read_miss", 1'b0, addr, '0, 4'h3, pattern_line(addr), 1'b0);
    if (u_mem.rd_count != rd0 + 1) begin
      note_mismatch("read_miss mem reads", rd0 + 1, u_mem.rd_count);
    end
    transact("read_hit", 1'b0, addr, '0, 4'h4, pattern_line(addr), 1'b0);
    if (u_mem.rd_count != rd0 + 1) begin
      note_mismatch("read_hit mem reads", rd0 + 1, u_mem.rd_count);
    end
    if (u_mem.wr_count != wr0) begin
      note_mismatch("read_hit mem writes", wr0, u_mem.wr_count);
    end
  endtask

  task automatic write_then_read();
    logic [31:0]        addr;
    l2_cache_pkg::blk_t data;
    int unsigned        rd0;
    int unsigned        wr0;
    addr = 32'h0000_2050;
    data = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
    rd0  = u_mem.rd_count;
    wr0  = u_mem.wr_count;
    transact("write_new", 1'b1, addr, data, 4'h5, data, 1'b0);
    transact("read_written", 1'b0, addr, '0, 4'h6, data, 1'b0);
    if (u_mem.rd_count != rd0 || u_mem.wr_count != wr0) begin
      note_failure("write_then_read caused memory traffic");
    end
  endtask

  // Four writes fill set 9, the fifth line evicts the first one
  task automatic eviction_order();
    logic [31:0]        addr [5];
    l2_cache_pkg::blk_t data [4];
    int unsigned        rd0;
    int unsigned        wr0;
    for (int k = 0; k < 5; k++) begin
      addr[k] = 32'h0004_0090 + (k << 12);
    end
    wr0 = u_mem.wr_count;
    for (int k = 0; k < 4; k++) begin
      data[k] = {4{32'hd00d_0000 + k}};
      transact("evict_fill", 1'b1, addr[k], data[k], 4'(k), data[k], 1'b0);
    end
    rd0 = u_mem.rd_count;
    transact("evict_read", 1'b0, addr[4], '0, 4'h9, pattern_line(addr[4]), 1'b0);
    if (u_mem.wr_count != wr0 + 1) begin
      note_mismatch("evict writebacks", wr0 + 1, u_mem.wr_count);
    end else begin
      if (u_mem.wr_addr_log[wr0] !== addr[0]) begin
        note_mismatch("evict writeback addr", addr[0], u_mem.wr_addr_log[wr0]);
      end
      if (u_mem.wr_data_log[wr0] !== data[0]) begin
        note_mismatch("evict writeback data", data[0], u_mem.wr_data_log[wr0]);
      end
    end
    if (u_mem.rd_count != rd0 + 1) begin
      note_mismatch("evict mem reads", rd0 + 1, u_mem.rd_count);
    end
  endtask

  // Reads use a small line pool, writes go to lines that are never read again
  task automatic backpressure_mix();
    logic [31:0]        r;
    logic [31:0]        addr;
    l2_cache_pkg::blk_t data;
    for (int i = 0; i < 12; i++) begin
      r = next_rand();
      if (i % 3 == 2) begin
        addr = {8'ha0, 8'(i), 8'h00, r[27:24], 4'h0};
        data = {next_rand(), next_rand(), next_rand(), next_rand()};
        transact("bp_write", 1'b1, addr, data, 4'(i), data, 1'b1);
      end else begin
        addr = {20'h50000, 2'b00, r[17:16], r[23:20], 4'h0};
        transact("bp_read", 1'b0, addr, '0, 4'(i), pattern_line(addr), 1'b1);
      end
    end
  endtask

  task automatic flush_drops_dirty();
    logic [31:0] addr;
    int unsigned rd0;
    int unsigned wr0;
    addr = 32'h0000_3070;
    transact("flush_write", 1'b1, addr, {4{32'hfeed_f00d}}, 4'hc, {4{32'hfeed_f00d}}, 1'b0);
    wr0 = u_mem.wr_count;
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    rd0 = u_mem.rd_count;
    transact("flush_read", 1'b0, addr, '0, 4'hd, pattern_line(addr), 1'b0);
    if (u_mem.rd_count != rd0 + 1) begin
      note_mismatch("flush_read mem reads", rd0 + 1, u_mem.rd_count);
    end
    if (u_mem.wr_count != wr0) begin
      note_failure("flushed dirty line was written back");
    end
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    req_valid_i = 1'b0;
    req_we_i    = 1'b0;
    req_addr_i  = '0;
    req_data_i  = '0;
    req_id_i    = '0;
    rsp_ready_i = 1'b1;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    read_miss_then_hit();
    write_then_read();
    eviction_order();
    backpressure_mix();
    flush_drops_dirty();
    repeat (4) @(posedge clk_i);
    $display("Errors: %0d value, %0d other, %0d assertion",
             value_errs, other_errs, DUT.u_assert.fail_cnt);
    if (value_errs == 0 && other_errs == 0 && DUT.u_assert.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog/l2_array_if.sv
`timescale 1ns/1ps
/*
 * Controller to tag/data array link
 * Lookup index, fill and dirty strobes one way, hit and victim readout the other
 */
interface l2_array_if;

  // Driven by the controller
  l2_cache_pkg::idx_t idx;
  l2_cache_pkg::way_t wr_way;
  l2_cache_pkg::tag_t wr_tag;
  l2_cache_pkg::blk_t wr_data;
  logic               dirty_set;
  logic               dirty_clr;
  logic               flush_en;
  logic               touch;

  // Driven by the array, valid one cycle after idx
  logic               hit;
  l2_cache_pkg::way_t hit_way;
  l2_cache_pkg::blk_t hit_data;
  l2_cache_pkg::way_t victim_way;
  l2_cache_pkg::tag_t victim_tag;
  l2_cache_pkg::blk_t victim_data;
  logic               victim_dirty;

  modport ctrl (
    output idx, wr_way, wr_tag, wr_data, dirty_set, dirty_clr, flush_en, touch,
    input  hit, hit_way, hit_data, victim_way, victim_tag, victim_data, victim_dirty
  );

  modport array (
    input  idx, wr_way, wr_tag, wr_data, dirty_set, dirty_clr, flush_en, touch,
    output hit, hit_way, hit_data, victim_way, victim_tag, victim_data, victim_dirty
  );

endinterface

// File: verilog/l2_cache_pkg.sv
/*
 * L2 cache package
 * Geometry constants and shared types of the 4-way, 16-set write-back cache
 */
package l2_cache_pkg;

  // ============================================================
  // Geometry
  // ============================================================
  localparam int unsigned ADDR_W  = 32;
  localparam int unsigned BLK_W   = 128;
  localparam int unsigned ID_W    = 4;
  localparam int unsigned NUM_WAY = 4;
  localparam int unsigned NUM_SET = 16;

  // Address split into tag, set index and byte offset
  localparam int unsigned BOFF_W = $clog2(BLK_W / 8);
  localparam int unsigned IDX_W  = $clog2(NUM_SET);
  localparam int unsigned TAG_W  = ADDR_W - IDX_W - BOFF_W;

  // ============================================================
  // Types
  // ============================================================
  typedef logic [BLK_W-1:0] blk_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [IDX_W-1:0] idx_t;

  // One-hot way select
  typedef logic [NUM_WAY-1:0] way_t;

  // Tree pseudo-LRU bits for one set, heap order with the root at bit 0
  typedef logic [NUM_WAY-2:0] node_t;

  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

endpackage

// File: verilog/l2_cache_top.sv
`timescale 1ns/1ps
/*
 * L2 cache top level
 * Blocking 4-way write-back cache between the level above and memory
 */
module l2_cache_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           flush_i,
  // Request from the level above
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  input  logic                           req_we_i,
  input  logic [l2_cache_pkg::ADDR_W-1:0] req_addr_i,
  input  l2_cache_pkg::blk_t             req_data_i,
  input  logic [l2_cache_pkg::ID_W-1:0]   req_id_i,
  // Response
  output logic                           rsp_valid_o,
  input  logic                           rsp_ready_i,
  output l2_cache_pkg::blk_t             rsp_data_o,
  output logic [l2_cache_pkg::ID_W-1:0]   rsp_id_o,
  // Memory side
  output logic                           mem_req_valid_o,
  input  logic                           mem_req_ready_i,
  output logic                           mem_req_we_o,
  output logic [l2_cache_pkg::ADDR_W-1:0] mem_req_addr_o,
  output l2_cache_pkg::blk_t             mem_req_data_o,
  input  logic                           mem_rsp_valid_i,
  input  l2_cache_pkg::blk_t             mem_rsp_data_i
);

  l2_array_if arr_if ();

  l2_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_we_i        (req_we_i),
    .req_addr_i      (req_addr_i),
    .req_data_i      (req_data_i),
    .req_id_i        (req_id_i),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .rsp_data_o      (rsp_data_o),
    .rsp_id_o        (rsp_id_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_we_o    (mem_req_we_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_data_o  (mem_req_data_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_data_i  (mem_rsp_data_i),
    .arr             (arr_if.ctrl)
  );

  l2_tag_data_array u_array (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .arr    (arr_if.array)
  );

endmodule

// File: verilog/l2_ctrl.sv
`timescale 1ns/1ps
/*
 * L2 cache controller
 * Blocking FSM for lookup, writeback, refill and flush sweep
 */
module l2_ctrl (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           flush_i,
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  input  logic                           req_we_i,
  input  logic [l2_cache_pkg::ADDR_W-1:0] req_addr_i,
  input  l2_cache_pkg::blk_t             req_data_i,
  input  logic [l2_cache_pkg::ID_W-1:0]   req_id_i,
  output logic                           rsp_valid_o,
  input  logic                           rsp_ready_i,
  output l2_cache_pkg::blk_t             rsp_data_o,
  output logic [l2_cache_pkg::ID_W-1:0]   rsp_id_o,
  output logic                           mem_req_valid_o,
  input  logic                           mem_req_ready_i,
  output logic                           mem_req_we_o,
  output logic [l2_cache_pkg::ADDR_W-1:0] mem_req_addr_o,
  output l2_cache_pkg::blk_t             mem_req_data_o,
  input  logic                           mem_rsp_valid_i,
  input  l2_cache_pkg::blk_t             mem_rsp_data_i,
  l2_array_if.ctrl                       arr
);

  typedef enum logic [2:0] {
    S_FLUSH, S_IDLE, S_LOOKUP, S_WRITEBACK, S_REFILL, S_RESPOND
  } state_t;

  state_t                          state_q;
  l2_cache_pkg::idx_t              flush_idx_q;
  logic                            flush_pend_q;
  logic                            rd_phase_q;
  logic                            req_we_q;
  logic [l2_cache_pkg::ADDR_W-1:0] req_addr_q;
  l2_cache_pkg::blk_t              req_data_q;
  logic [l2_cache_pkg::ID_W-1:0]   req_id_q;
  l2_cache_pkg::way_t              fill_way_q;
  l2_cache_pkg::tag_t              req_tag;
  l2_cache_pkg::idx_t              req_idx;
  logic [l2_cache_pkg::ADDR_W-1:0] line_addr;
  logic                            req_fire;
  logic                            mem_fire;

  assign req_tag   = req_addr_q[l2_cache_pkg::ADDR_W-1 -: l2_cache_pkg::TAG_W];
  assign req_idx   = req_addr_q[l2_cache_pkg::BOFF_W +: l2_cache_pkg::IDX_W];
  assign line_addr = {req_addr_q[l2_cache_pkg::ADDR_W-1:l2_cache_pkg::BOFF_W],
                      {l2_cache_pkg::BOFF_W{1'b0}}};

  assign req_ready_o = (state_q == S_IDLE) && !flush_pend_q && !flush_i;
  assign req_fire    = req_valid_i && req_ready_o;
  assign mem_fire    = mem_req_valid_o && mem_req_ready_i;
  assign rsp_id_o    = req_id_q;

  // ============================================================
  // Array strobes
  // ============================================================
  always_comb begin
    arr.idx       = (state_q == S_FLUSH) ? flush_idx_q : req_idx;
    arr.wr_tag    = req_tag;
    arr.wr_data   = req_data_q;
    arr.wr_way    = '0;
    arr.dirty_set = 1'b0;
    arr.dirty_clr = 1'b0;
    arr.flush_en  = (state_q == S_FLUSH);
    arr.touch     = 1'b0;
    case (state_q)
      S_LOOKUP: begin
        if (rd_phase_q && arr.hit) begin
          arr.touch = 1'b1;
          if (req_we_q) begin
            arr.wr_way    = arr.hit_way;
            arr.dirty_set = 1'b1;
          end
        end else if (rd_phase_q && req_we_q && !arr.victim_dirty) begin
          // Full-line write miss, no fetch needed
          arr.wr_way    = arr.victim_way;
          arr.dirty_set = 1'b1;
          arr.touch     = 1'b1;
        end
      end
      S_WRITEBACK: begin
        if (mem_rsp_valid_i && req_we_q) begin
          arr.wr_way    = fill_way_q;
          arr.dirty_set = 1'b1;
          arr.touch     = 1'b1;
        end
      end
      S_REFILL: begin
        if (mem_rsp_valid_i) begin
          arr.wr_way    = fill_way_q;
          arr.wr_data   = mem_rsp_data_i;
          arr.dirty_clr = 1'b1;
          arr.touch     = 1'b1;
        end
      end
      default: ;
    endcase
  end

  // ============================================================
  // State machine
  // ============================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q         <= S_FLUSH;
      flush_idx_q     <= '0;
      flush_pend_q    <= 1'b0;
      rd_phase_q      <= 1'b0;
      mem_req_valid_o <= 1'b0;
      rsp_valid_o     <= 1'b0;
    end else begin
      // Flush requests during a transaction wait for idle
      if (flush_i && (state_q != S_IDLE) && (state_q != S_FLUSH)) begin
        flush_pend_q <= 1'b1;
      end
      if (mem_fire) begin
        mem_req_valid_o <= 1'b0;
      end
      case (state_q)
        S_FLUSH: begin
          flush_idx_q <= flush_idx_q + 1'b1;
          if (flush_idx_q == l2_cache_pkg::IDX_W'(l2_cache_pkg::NUM_SET - 1)) begin
            state_q <= S_IDLE;
          end
        end
        S_IDLE: begin
          if (flush_i || flush_pend_q) begin
            flush_idx_q  <= '0;
            flush_pend_q <= 1'b0;
            state_q      <= S_FLUSH;
          end else if (req_fire) begin
            req_we_q   <= req_we_i;
            req_addr_q <= req_addr_i;
            req_data_q <= req_data_i;
            req_id_q   <= req_id_i;
            rd_phase_q <= 1'b0;
            state_q    <= S_LOOKUP;
          end
        end
        S_LOOKUP: begin
          // First cycle reads the RAMs, second one decides
          rd_phase_q <= 1'b1;
          if (rd_phase_q) begin
            fill_way_q <= arr.victim_way;
            if (arr.hit) begin
              rsp_data_o  <= req_we_q ? req_data_q : arr.hit_data;
              rsp_valid_o <= 1'b1;
              state_q     <= S_RESPOND;
            end else if (arr.victim_dirty) begin
              mem_req_valid_o <= 1'b1;
              mem_req_we_o    <= 1'b1;
              mem_req_addr_o  <= {arr.victim_tag, req_idx, {l2_cache_pkg::BOFF_W{1'b0}}};
              mem_req_data_o  <= arr.victim_data;
              state_q         <= S_WRITEBACK;
            end else if (req_we_q) begin
              rsp_data_o  <= req_data_q;
              rsp_valid_o <= 1'b1;
              state_q     <= S_RESPOND;
            end else begin
              mem_req_valid_o <= 1'b1;
              mem_req_we_o    <= 1'b0;
              mem_req_addr_o  <= line_addr;
              state_q         <= S_REFILL;
            end
          end
        end
        S_WRITEBACK: begin
          if (mem_rsp_valid_i && req_we_q) begin
            rsp_data_o  <= req_data_q;
            rsp_valid_o <= 1'b1;
            state_q     <= S_RESPOND;
          end else if (mem_rsp_valid_i) begin
            mem_req_valid_o <= 1'b1;
            mem_req_we_o    <= 1'b0;
            mem_req_addr_o  <= line_addr;
            state_q         <= S_REFILL;
          end
        end
        S_REFILL: begin
          if (mem_rsp_valid_i) begin
            rsp_data_o  <= mem_rsp_data_i;
            rsp_valid_o <= 1'b1;
            state_q     <= S_RESPOND;
          end
        end
        S_RESPOND: begin
          if (rsp_ready_i) begin
            rsp_valid_o <= 1'b0;
            state_q     <= S_IDLE;
          end
        end
        default: state_q <= S_FLUSH;
      endcase
    end
  end

endmodule

// File: verilog/l2_plru_tree.sv
`timescale 1ns/1ps
/*
 * Tree pseudo-LRU replacement state
 * One node vector per set, victim returned a cycle after the index
 */
module l2_plru_tree (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  l2_cache_pkg::idx_t idx_i,
  input  logic               touch_i,
  input  l2_cache_pkg::way_t touch_way_i,
  input  logic               flush_i,
  output l2_cache_pkg::way_t victim_way_o
);

  l2_cache_pkg::node_t nodes_q [l2_cache_pkg::NUM_SET];
  l2_cache_pkg::idx_t  idx_q;

  // Walk from the root, bit clear means go left
  function automatic l2_cache_pkg::way_t pick_victim(input l2_cache_pkg::node_t node);
    int unsigned        pos;
    l2_cache_pkg::way_t way;
    pos = 0;
    for (int unsigned lvl = 0; lvl < $clog2(l2_cache_pkg::NUM_WAY); lvl++) begin
      pos = 2 * pos + 1 + node[pos];
    end
    way = '0;
    way[pos - (l2_cache_pkg::NUM_WAY - 1)] = 1'b1;
    return way;
  endfunction

  // Climb from the touched leaf and point each parent at the other child
  function automatic l2_cache_pkg::node_t point_away(input l2_cache_pkg::node_t node,
                                                     input l2_cache_pkg::way_t way);
    l2_cache_pkg::node_t res;
    int unsigned         pos;
    int unsigned         parent;
    res = node;
    pos = l2_cache_pkg::NUM_WAY - 1;
    for (int unsigned w = 0; w < l2_cache_pkg::NUM_WAY; w++) begin
      if (way[w]) begin
        pos = w + l2_cache_pkg::NUM_WAY - 1;
      end
    end
    for (int unsigned lvl = 0; lvl < $clog2(l2_cache_pkg::NUM_WAY); lvl++) begin
      parent      = (pos - 1) / 2;
      res[parent] = (pos == 2 * parent + 1);
      pos         = parent;
    end
    return res;
  endfunction

  always_ff @(posedge clk_i) begin
    idx_q <= idx_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int s = 0; s < l2_cache_pkg::NUM_SET; s++) begin
        nodes_q[s] <= '0;
      end
    end else if (flush_i) begin
      nodes_q[idx_i] <= '0;
    end else if (touch_i) begin
      nodes_q[idx_i] <= point_away(nodes_q[idx_i], touch_way_i);
    end
  end

  assign victim_way_o = pick_victim(nodes_q[idx_q]);

endmodule

// File: verilog/l2_sp_ram.sv
`timescale 1ns/1ps
/*
 * Single-port synchronous RAM with registered read
 * Word type is a parameter so tags and lines share one block
 */
module l2_sp_ram #(
  parameter type         word_t = l2_cache_pkg::blk_t,
  parameter int unsigned DEPTH  = l2_cache_pkg::NUM_SET
) (
  input  logic               clk_i,
  input  logic               we_i,
  input  l2_cache_pkg::idx_t addr_i,
  input  word_t              wdata_i,
  output word_t              rdata_o
);

  word_t mem_q [DEPTH];

  // Read returns the old word on a write cycle
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    rdata_o <= mem_q[addr_i];
  end

endmodule

// File: verilog/l2_tag_data_array.sv
`timescale 1ns/1ps
/*
 * Tag, data and dirty storage of the L2 cache
 * Compares stored tags against the lookup tag and reads out hit and victim lines
 */
module l2_tag_data_array (
  input logic         clk_i,
  input logic         rst_ni,
  l2_array_if.array   arr
);

  l2_cache_pkg::tag_entry_t rd_tag [l2_cache_pkg::NUM_WAY];
  l2_cache_pkg::blk_t       rd_data [l2_cache_pkg::NUM_WAY];
  l2_cache_pkg::tag_entry_t tag_wdata;
  l2_cache_pkg::way_t       dirty_q [l2_cache_pkg::NUM_SET];
  l2_cache_pkg::idx_t       idx_q;
  l2_cache_pkg::tag_t       tag_q;
  l2_cache_pkg::way_t       hit_vec;
  l2_cache_pkg::way_t       touch_way;
  l2_cache_pkg::way_t       victim_way;

  // ============================================================
  // Storage
  // ============================================================

  // Flush writes an invalid entry into every way of the set
  always_comb begin
    if (arr.flush_en) begin
      tag_wdata = '0;
    end else begin
      tag_wdata = l2_cache_pkg::tag_entry_t'{valid: 1'b1, tag: arr.wr_tag};
    end
  end

  for (genvar w = 0; w < l2_cache_pkg::NUM_WAY; w++) begin : g_way
    l2_sp_ram #(
      .word_t (l2_cache_pkg::tag_entry_t),
      .DEPTH  (l2_cache_pkg::NUM_SET)
    ) u_tag_ram (
      .clk_i   (clk_i),
      .we_i    (arr.flush_en | arr.wr_way[w]),
      .addr_i  (arr.idx),
      .wdata_i (tag_wdata),
      .rdata_o (rd_tag[w])
    );

    l2_sp_ram #(
      .word_t (l2_cache_pkg::blk_t),
      .DEPTH  (l2_cache_pkg::NUM_SET)
    ) u_data_ram (
      .clk_i   (clk_i),
      .we_i    (arr.wr_way[w]),
      .addr_i  (arr.idx),
      .wdata_i (arr.wr_data),
      .rdata_o (rd_data[w])
    );

    assign hit_vec[w] = rd_tag[w].valid && (rd_tag[w].tag == tag_q);
  end

  // Lookup tag travels with the index so the compare lines up with the RAM read
  always_ff @(posedge clk_i) begin
    idx_q <= arr.idx;
    tag_q <= arr.wr_tag;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int s = 0; s < l2_cache_pkg::NUM_SET; s++) begin
        dirty_q[s] <= '0;
      end
    end else if (arr.flush_en) begin
      dirty_q[arr.idx] <= '0;
    end else if (arr.dirty_set) begin
      dirty_q[arr.idx] <= dirty_q[arr.idx] | arr.wr_way;
    end else if (arr.dirty_clr) begin
      dirty_q[arr.idx] <= dirty_q[arr.idx] & ~arr.wr_way;
    end
  end

  // ============================================================
  // Replacement
  // ============================================================

  // A fill touches the written way, a read hit touches the hit way
  assign touch_way = (|arr.wr_way) ? arr.wr_way : hit_vec;

  l2_plru_tree u_plru (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .idx_i        (arr.idx),
    .touch_i      (arr.touch),
    .touch_way_i  (touch_way),
    .flush_i      (arr.flush_en),
    .victim_way_o (victim_way)
  );

  // ============================================================
  // Readout
  // ============================================================
  always_comb begin
    arr.hit_data    = '0;
    arr.victim_tag  = '0;
    arr.victim_data = '0;
    for (int w = 0; w < l2_cache_pkg::NUM_WAY; w++) begin
      if (hit_vec[w]) begin
        arr.hit_data = rd_data[w];
      end
      if (victim_way[w]) begin
        arr.victim_tag  = rd_tag[w].tag;
        arr.victim_data = rd_data[w];
      end
    end
  end

  assign arr.hit          = |hit_vec;
  assign arr.hit_way      = hit_vec;
  assign arr.victim_way   = victim_way;
  assign arr.victim_dirty = |(dirty_q[idx_q] & victim_way);

endmodule
